//--- design/fe_pkg.sv
package fe_pkg;

  // address and storage sizes
  localparam int vaddr_width_lp     = 32;
  localparam int imem_depth_lp      = 256;  // words
  localparam int imem_addr_width_lp = 8;
  localparam int queue_depth_lp     = 4;
  localparam int queue_ptr_width_lp = 2;

  // two halfword parcels of one fetch word, hi at the higher address
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } parcel_s;

  // one fetch word, read whole or as two parcels
  typedef union packed {
    logic [31:0] full;
    parcel_s     parcel;
  } fetch_word_u;

  // pc of the fetched word with the word itself
  typedef struct packed {
    logic [vaddr_width_lp-1:0] pc;
    fetch_word_u               word;
  } fe_fetch_s;

  // finished instruction as handed to the back end
  typedef struct packed {
    logic [vaddr_width_lp-1:0] pc;
    logic [31:0]               instr;         // compressed ones zero extended
    logic                      iscompressed;
    logic                      isfirstinstr;  // low for the 2nd parcel of a word
  } fe_inst_s;

endpackage

//--- design/fe_imem.sv
`timescale 1ns/1ps

module fe_imem (
  input  logic                                  clk_i,
  input  logic                                  we_i,
  input  logic [fe_pkg::imem_addr_width_lp-1:0] waddr_i,
  input  logic [31:0]                           wdata_i,
  input  logic [fe_pkg::vaddr_width_lp-1:0]     pc_i,
  output fe_pkg::fetch_word_u                   word_o
);

  logic [31:0] mem_q [fe_pkg::imem_depth_lp];
  logic [fe_pkg::imem_addr_width_lp-1:0] raddr;

  // word index, the low two pc bits select a halfword only
  assign raddr = pc_i[fe_pkg::imem_addr_width_lp+1:2];

  // load port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign word_o.full = mem_q[raddr];  // async read

endmodule

//--- design/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              redirect_v_i,
  input  logic [fe_pkg::vaddr_width_lp-1:0] redirect_pc_i,
  input  logic                              fetch_ready_i,
  output logic                              fetch_v_o,
  output logic [fe_pkg::vaddr_width_lp-1:0] fetch_pc_o
);

  logic [fe_pkg::vaddr_width_lp-1:0] pc_q;
  logic [fe_pkg::vaddr_width_lp-1:0] pc_next_word;
  logic                              run_q;  // set by the first redirect

  // next word boundary, a halfword pc drops bit 1 here
  assign pc_next_word = {pc_q[fe_pkg::vaddr_width_lp-1:2] + 1'b1, 2'b00};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q  <= '0;
      run_q <= 1'b0;
    end else if (redirect_v_i) begin
      pc_q  <= redirect_pc_i;
      run_q <= 1'b1;
    end else if (run_q && fetch_ready_i) begin
      pc_q  <= pc_next_word;  // word consumed by the aligner
    end
  end

  assign fetch_v_o  = run_q;
  assign fetch_pc_o = pc_q;

  // only word and halfword fetch addresses exist in RV32C
  pc_halfword_aligned_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fetch_v_o |-> !fetch_pc_o[0]
  ) else $error("fetch pc not halfword aligned: %h", fetch_pc_o);

endmodule

//--- design/fe_aligner.sv
`timescale 1ns/1ps

module fe_aligner (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  fe_pkg::fe_fetch_s fetch_i,
  input  logic              fetch_v_i,
  output logic              fetch_ready_o,
  input  logic              queue_ready_i,
  output logic              inst_v_o,
  output fe_pkg::fe_inst_s  inst_o
);

  // upper parcel of an instruction that crosses into the next word
  logic                              pend_v_q;
  logic                              pend_v_n;
  logic [15:0]                       pend_parcel_q;
  logic [15:0]                       pend_parcel_n;
  logic [fe_pkg::vaddr_width_lp-1:0] pend_pc_q;
  logic [fe_pkg::vaddr_width_lp-1:0] pend_pc_n;

  logic second_q;  // word held for its upper compressed
  logic second_n;
  logic first_q;   // nothing emitted since the last redirect
  logic first_n;

  fe_pkg::fetch_word_u               word;
  logic [fe_pkg::vaddr_width_lp-1:0] upper_pc;
  logic                              go;
  logic                              lo_c;
  logic                              hi_c;

  assign word     = fetch_i.word;
  assign upper_pc = {fetch_i.pc[fe_pkg::vaddr_width_lp-1:2], 2'b10};
  assign go       = fetch_v_i && queue_ready_i;  // full queue freezes everything

  // low bits 11 start a 32-bit instruction
  assign lo_c = word.parcel.lo[1:0] != 2'b11;
  assign hi_c = word.parcel.hi[1:0] != 2'b11;

  always_comb begin
    pend_v_n      = pend_v_q;
    pend_parcel_n = pend_parcel_q;
    pend_pc_n     = pend_pc_q;
    second_n      = second_q;
    first_n       = first_q;

    fetch_ready_o       = 1'b0;
    inst_v_o            = 1'b0;
    inst_o.pc           = fetch_i.pc;
    inst_o.instr        = word.full;
    inst_o.iscompressed = 1'b0;

    if (go) begin
      if (second_q) begin
        // upper compressed of the held word
        inst_v_o            = 1'b1;
        inst_o.pc           = upper_pc;
        inst_o.instr        = {16'b0, word.parcel.hi};
        inst_o.iscompressed = 1'b1;
        second_n            = 1'b0;
        fetch_ready_o       = 1'b1;
      end else if (fetch_i.pc[1]) begin
        // lower parcel of a halfword target belongs to older code
        fetch_ready_o = 1'b1;
        if (hi_c) begin
          inst_v_o            = 1'b1;
          inst_o.pc           = upper_pc;
          inst_o.instr        = {16'b0, word.parcel.hi};
          inst_o.iscompressed = 1'b1;
        end else begin
          pend_v_n      = 1'b1;  // wait for the next word
          pend_parcel_n = word.parcel.hi;
          pend_pc_n     = upper_pc;
        end
      end else begin
        inst_v_o = 1'b1;
        if (pend_v_q) begin
          // finish the crossing instruction
          inst_o.pc    = pend_pc_q;
          inst_o.instr = {word.parcel.lo, pend_parcel_q};
        end else if (lo_c) begin
          inst_o.instr        = {16'b0, word.parcel.lo};
          inst_o.iscompressed = 1'b1;
        end

        if (!pend_v_q && !lo_c) begin
          fetch_ready_o = 1'b1;  // plain aligned 32-bit word
        end else if (hi_c) begin
          pend_v_n = 1'b0;
          second_n = 1'b1;
        end else begin
          pend_v_n      = 1'b1;
          pend_parcel_n = word.parcel.hi;
          pend_pc_n     = upper_pc;
          fetch_ready_o = 1'b1;
        end
      end
    end

    inst_o.isfirstinstr = !(inst_o.iscompressed && inst_o.pc[1]) || first_q;
    if (inst_v_o) begin
      first_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_v_q <= 1'b0;
      second_q <= 1'b0;
      first_q  <= 1'b0;
    end else if (flush_i) begin
      pend_v_q <= 1'b0;
      second_q <= 1'b0;
      first_q  <= 1'b1;
    end else begin
      pend_v_q <= pend_v_n;
      second_q <= second_n;
      first_q  <= first_n;
    end
  end

  // pending parcel data, meaningful only with pend_v_q
  always_ff @(posedge clk_i) begin
    pend_parcel_q <= pend_parcel_n;
    pend_pc_q     <= pend_pc_n;
  end

  no_emit_when_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    inst_v_o |-> queue_ready_i
  ) else $error("aligner emitted into a full queue");

  // the pc stays on the held word until its upper parcel is out
  hold_keeps_pc_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    second_q |-> $stable(fetch_i.pc)
  ) else $error("fetch pc moved while a word was held");

endmodule

//--- design/fe_queue.sv
`timescale 1ns/1ps

module fe_queue (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             enq_v_i,
  input  fe_pkg::fe_inst_s enq_i,
  output logic             ready_o,
  input  logic             deq_i,
  output logic             inst_v_o,
  output fe_pkg::fe_inst_s inst_o
);

  fe_pkg::fe_inst_s mem_q [fe_pkg::queue_depth_lp];

  logic [fe_pkg::queue_ptr_width_lp-1:0] wr_ptr_q;
  logic [fe_pkg::queue_ptr_width_lp-1:0] rd_ptr_q;
  logic [fe_pkg::queue_ptr_width_lp:0]   count_q;  // one extra bit for full
  logic                                  do_enq;
  logic                                  do_deq;

  assign ready_o  = count_q != fe_pkg::queue_depth_lp;
  assign inst_v_o = count_q != '0;
  assign inst_o   = mem_q[rd_ptr_q];

  assign do_enq = enq_v_i && ready_o;
  assign do_deq = deq_i && inst_v_o;  // empty queue ignores deq

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      end
      if (do_deq) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_enq && !do_deq) begin
        count_q <= count_q + 1'b1;
      end else if (do_deq && !do_enq) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_enq && !flush_i) begin
      mem_q[wr_ptr_q] <= enq_i;
    end
  end

  // producer must watch ready_o
  no_enq_when_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (enq_v_i && !flush_i) |-> count_q != fe_pkg::queue_depth_lp
  ) else $error("enqueue into full instruction queue");

endmodule

//--- design/fe_top.sv
`timescale 1ns/1ps

module fe_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  imem_we_i,
  input  logic [fe_pkg::imem_addr_width_lp-1:0] imem_addr_i,
  input  logic [31:0]                           imem_data_i,
  input  logic                                  redirect_v_i,
  input  logic [fe_pkg::vaddr_width_lp-1:0]     redirect_pc_i,
  input  logic                                  deq_i,
  output logic                                  inst_v_o,
  output fe_pkg::fe_inst_s                      inst_o
);

  logic [fe_pkg::vaddr_width_lp-1:0] fetch_pc;
  logic                              fetch_v;
  logic                              fetch_ready;
  fe_pkg::fetch_word_u               imem_word;
  fe_pkg::fe_fetch_s                 fetch;
  logic                              queue_ready;
  logic                              al_inst_v;
  fe_pkg::fe_inst_s                  al_inst;

  assign fetch.pc   = fetch_pc;
  assign fetch.word = imem_word;

  fe_pc_gen pc_gen_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .redirect_v_i (redirect_v_i),
    .redirect_pc_i(redirect_pc_i),
    .fetch_ready_i(fetch_ready),
    .fetch_v_o    (fetch_v),
    .fetch_pc_o   (fetch_pc)
  );

  fe_imem imem_i (
    .clk_i  (clk_i),
    .we_i   (imem_we_i),
    .waddr_i(imem_addr_i),
    .wdata_i(imem_data_i),
    .pc_i   (fetch_pc),
    .word_o (imem_word)
  );

  fe_aligner aligner_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (redirect_v_i),  // redirect drops any split parcel
    .fetch_i      (fetch),
    .fetch_v_i    (fetch_v),
    .fetch_ready_o(fetch_ready),
    .queue_ready_i(queue_ready),
    .inst_v_o     (al_inst_v),
    .inst_o       (al_inst)
  );

  fe_queue queue_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (redirect_v_i),
    .enq_v_i (al_inst_v),
    .enq_i   (al_inst),
    .ready_o (queue_ready),
    .deq_i   (deq_i),
    .inst_v_o(inst_v_o),
    .inst_o  (inst_o)
  );

endmodule

//--- test/tb_fe_top.sv
`timescale 1ns/1ps

module tb_fe_top;

  logic                                  clk_i;
  logic                                  rst_n_i;
  logic                                  imem_we_i;
  logic [fe_pkg::imem_addr_width_lp-1:0] imem_addr_i;
  logic [31:0]                           imem_data_i;
  logic                                  redirect_v_i;
  logic [31:0]                           redirect_pc_i;
  logic                                  deq_i;
  logic                                  inst_v_o;
  fe_pkg::fe_inst_s                      inst_o;

  logic [31:0] prog [fe_pkg::imem_depth_lp];  // copy of the DUT memory image
  logic [31:0] rng_state;
  logic [31:0] start_pc;      // pc of the last redirect
  string       test_name;
  logic        checking;
  int          expect_count;
  int          n_seen;        // dequeued items since the last redirect
  int          full_cycles;   // cycles with a full queue in the last stream

  fe_top fe_top_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .imem_we_i    (imem_we_i),
    .imem_addr_i  (imem_addr_i),
    .imem_data_i  (imem_data_i),
    .redirect_v_i (redirect_v_i),
    .redirect_pc_i(redirect_pc_i),
    .deq_i        (deq_i),
    .inst_v_o     (inst_v_o),
    .inst_o       (inst_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // word index wraps like the DUT memory
  function automatic logic [15:0] halfword_at(input logic [31:0] addr);
    logic [31:0] word;
    word = prog[addr[fe_pkg::imem_addr_width_lp+1:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // n-th instruction of the stream that starts at start
  function automatic fe_pkg::fe_inst_s ref_inst(input logic [31:0] start, input int n);
    fe_pkg::fe_inst_s r;
    logic [31:0]      pc;
    logic [15:0]      lo;
    logic [15:0]      hi;
    logic [31:0]      end_word;  // word that holds the last parcel
    logic [31:0]      prev_end;
    int               i;
    pc       = start;
    r        = '0;
    prev_end = '0;
    for (i = 0; i <= n; i++) begin
      lo   = halfword_at(pc);
      r.pc = pc;
      if (lo[1:0] != 2'b11) begin
        r.instr        = {16'b0, lo};  // compressed
        r.iscompressed = 1'b1;
        pc             = pc + 32'd2;
      end else begin
        hi             = halfword_at(pc + 32'd2);
        r.instr        = {hi, lo};
        r.iscompressed = 1'b0;
        pc             = pc + 32'd4;
      end
      // second instruction finished out of one fetch word
      end_word       = (pc - 32'd2) >> 2;
      r.isfirstinstr = (i == 0) || (end_word != prev_end);
      prev_end       = end_word;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input int index,
                             input logic [65:0] expected, input logic [65:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s item %0d expected %h actual %h",
               name, index, expected, actual);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // kind 0 only 32-bit, kind 1 only compressed, kind 2 random mix
  task automatic load_program(input int kind);
    logic [15:0] lo;
    logic [15:0] hi;
    int          i;
    for (i = 0; i < fe_pkg::imem_depth_lp; i++) begin
      lo = lcg_next() >> 16;
      hi = lcg_next() >> 16;
      if (kind == 0) begin
        lo[1:0] = 2'b11;
      end else if (kind == 1) begin
        if (lo[1:0] == 2'b11) lo[1] = 1'b0;
        if (hi[1:0] == 2'b11) hi[1] = 1'b0;
      end
      prog[i]     = {hi, lo};
      imem_we_i   = 1'b1;
      imem_addr_i = i[fe_pkg::imem_addr_width_lp-1:0];
      imem_data_i = {hi, lo};
      next_cycle();
    end
    imem_we_i = 1'b0;
  endtask

  // deq held low through the redirect cycle
  task automatic start_at(input logic [31:0] pc);
    deq_i         = 1'b0;
    redirect_v_i  = 1'b1;
    redirect_pc_i = pc;
    start_pc      = pc;
    next_cycle();
    redirect_v_i  = 1'b0;
  endtask

  task automatic run_stream(input string name, input logic [31:0] pc,
                            input int count, input logic random_deq);
    int cycles;
    test_name    = name;
    expect_count = count;
    checking     = 1'b1;
    full_cycles  = 0;
    start_at(pc);
    cycles = 0;
    while (n_seen < count) begin
      if (cycles >= count * 20 + 100) begin
        $display("timeout in %s after %0d of %0d instructions", name, n_seen, count);
        $display("TB FAILED");
        $fatal(1);
      end
      deq_i = random_deq ? (((lcg_next() >> 16) % 10) < 3) : 1'b1;  // ~30% rate
      next_cycle();
      cycles++;
      if (!fe_top_i.queue_ready) begin
        full_cycles++;
      end
    end
    deq_i    = 1'b0;
    checking = 1'b0;
  endtask

  // an item is taken at the edge after this sample
  always @(negedge clk_i) begin
    if (redirect_v_i) begin
      n_seen = 0;
    end else if (checking && deq_i && inst_v_o && n_seen < expect_count) begin
      check_value(test_name, n_seen, ref_inst(start_pc, n_seen), inst_o);
      n_seen++;
    end
  end

  initial begin
    logic [31:0] pc_c;
    logic [31:0] pc_w;
    logic [31:0] addr;
    logic [15:0] h;
    int          k;

    rst_n_i       = 1'b0;
    imem_we_i     = 1'b0;
    imem_addr_i   = '0;
    imem_data_i   = '0;
    redirect_v_i  = 1'b0;
    redirect_pc_i = '0;
    deq_i         = 1'b0;
    rng_state     = 32'hf9d9;
    start_pc      = '0;
    test_name     = "none";
    checking      = 1'b0;
    expect_count  = 0;
    n_seen        = 0;
    full_cycles   = 0;

    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // nothing fetched before the first redirect
    for (k = 0; k < 20; k++) begin
      check_value("reset idle", k, 66'd0, {65'd0, inst_v_o});
      next_cycle();
    end

    load_program(0);
    run_stream("aligned 32-bit", 32'h0, 100, 1'b0);

    load_program(1);
    run_stream("compressed pairs", 32'h0, 150, 1'b0);

    load_program(2);
    run_stream("random mix", 32'h0, 200, 1'b0);

    // halfword targets for one compressed and one 32-bit start
    pc_c = '0;
    pc_w = '0;
    for (k = 16; k < 200; k++) begin
      addr = k * 4 + 2;
      h    = halfword_at(addr);
      if (h[1:0] != 2'b11 && pc_c == 0) pc_c = addr;
      if (h[1:0] == 2'b11 && pc_w == 0) pc_w = addr;
    end
    if (pc_c == 0 || pc_w == 0) begin
      $display("no halfword redirect target found in the random program");
      $display("TB FAILED");
      $fatal(1);
    end

    start_at(32'h0);
    repeat (8) next_cycle();  // queue fills with older code
    run_stream("redirect compressed", pc_c, 40, 1'b0);
    start_at(32'h4);
    repeat (8) next_cycle();
    run_stream("redirect 32-bit", pc_w, 40, 1'b0);

    run_stream("random deq", 32'h0, 200, 1'b1);

    if (full_cycles > 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("queue never filled while dequeue was random");
      $display("TB FAILED");
      $fatal(1);
    end
  end

endmodule

//--- sources.f
design/fe_pkg.sv
design/fe_imem.sv
design/fe_pc_gen.sv
design/fe_aligner.sv
design/fe_queue.sv
design/fe_top.sv
test/tb_fe_top.sv

//--- Makefile
.PHONY: all run clean

all: obj_dir/Vtb_fe_top

obj_dir/Vtb_fe_top: sources.f $(wildcard design/*.sv) test/tb_fe_top.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_fe_top -f sources.f -o Vtb_fe_top

run: obj_dir/Vtb_fe_top
	./obj_dir/Vtb_fe_top

clean:
	rm -rf obj_dir
